// File: logic/xphy_pkg.sv
// ----------------------------------------------------------------------
// xphy package
// XGMII word type, control character codes, fault ordered-set codes
// and thresholds shared by the 10GBASE-R glue logic
// ----------------------------------------------------------------------
package xphy_pkg;

   // one 64-bit XGMII transfer, lane 0 in data[7:0] and ctrl[0]
   typedef struct packed {
      logic [63:0] data;
      logic [7:0]  ctrl;
   } xgmii_word_t;

   // control characters
   localparam logic [7:0] XGMII_IDLE     = 8'h07;
   localparam logic [7:0] XGMII_START    = 8'hFB;
   localparam logic [7:0] XGMII_ERROR    = 8'hFE;
   localparam logic [7:0] XGMII_SEQUENCE = 8'h9C;

   // lane 3 code of a sequence ordered set
   localparam logic [7:0] SEQ_LOCAL_FAULT  = 8'h01;
   localparam logic [7:0] SEQ_REMOTE_FAULT = 8'h02;

   // idle in all eight lanes
   localparam xgmii_word_t IDLE_WORD = '{
      data: {8{XGMII_IDLE}},
      ctrl: 8'hFF
   };

   // remote fault ordered set in both column halves
   localparam xgmii_word_t REMOTE_FAULT_WORD = '{
      data: {SEQ_REMOTE_FAULT, 8'h00, 8'h00, XGMII_SEQUENCE,
             SEQ_REMOTE_FAULT, 8'h00, 8'h00, XGMII_SEQUENCE},
      ctrl: 8'h11
   };

   // fault monitor thresholds, in consecutive words
   localparam int FAULT_SET_COUNT   = 4;
   localparam int FAULT_CLEAR_COUNT = 16;
   localparam int SET_CNT_WIDTH     = $clog2(FAULT_SET_COUNT + 1);
   localparam int CLEAR_CNT_WIDTH   = $clog2(FAULT_CLEAR_COUNT + 1);

   // statistics counters
   localparam int COUNT_WIDTH = 16;

   // reset synchronizer depth
   localparam int RESET_SYNC_STAGES = 2;

endpackage

// File: logic/phy_reset_ctrl.sv
// ----------------------------------------------------------------------
// phy reset controller
// holds the tx and rx core resets until the transceiver and optics
// are ready, then releases each through a short synchronizer
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module phy_reset_ctrl
   import xphy_pkg::*;
(
   input  logic clk156,
   input  logic reset,
   input  logic tx_resetdone,
   input  logic rx_resetdone,
   input  logic tx_fault,
   input  logic signal_detect,
   output logic resetdone,
   output logic core_reset_tx,
   output logic core_reset_rx
);

   // hold requests, high while a side is not ready
   logic hold_tx;
   logic hold_rx;

   // synchronizer chains, stage 0 samples the hold request
   logic [RESET_SYNC_STAGES-1:0] tx_sync;
   logic [RESET_SYNC_STAGES-1:0] rx_sync;

   // a fault on the laser or loss of light holds both sides
   assign hold_tx = !tx_resetdone || tx_fault || !signal_detect;
   assign hold_rx = !rx_resetdone || tx_fault || !signal_detect;

   // transceiver reset status straight through to the MAC side
   assign resetdone = tx_resetdone && rx_resetdone;

   // async preset puts both cores in reset at once,
   // release ripples through the chain one stage per clock
   always_ff @(posedge clk156 or posedge reset)
   begin
      if (reset)
      begin
         tx_sync <= '1;
         rx_sync <= '1;
      end
      else
      begin
         tx_sync <= {tx_sync[RESET_SYNC_STAGES-2:0], hold_tx};
         rx_sync <= {rx_sync[RESET_SYNC_STAGES-2:0], hold_rx};
      end
   end

   assign core_reset_tx = tx_sync[RESET_SYNC_STAGES-1];
   assign core_reset_rx = rx_sync[RESET_SYNC_STAGES-1];

   // system reset must keep both cores held
   a_reset_holds_cores: assert property (
      @(posedge clk156) reset |-> (core_reset_tx && core_reset_rx)
   );

endmodule

// File: logic/rx_input_stage.sv
// ----------------------------------------------------------------------
// receive input stage
// registers the PHY receive column, sends idle while the rx core is
// held and counts columns that carry error characters
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module rx_input_stage
   import xphy_pkg::*;
(
   input  logic                   clk156,
   input  logic                   reset,
   input  logic                   core_reset_rx,
   input  xgmii_word_t            xgmii_rx_phy,
   output xgmii_word_t            xgmii_rx,
   output logic [COUNT_WIDTH-1:0] rx_error_count
);

   // per-lane error hit and its reduction
   logic [7:0] lane_err;
   logic       word_err;

   // an error lane is a control lane holding the error character
   always_comb
   begin
      for (int i = 0; i < 8; i++)
      begin
         lane_err[i] = xgmii_rx_phy.ctrl[i] &&
                       (xgmii_rx_phy.data[8*i +: 8] == XGMII_ERROR);
      end
   end

   assign word_err = |lane_err;

   // idle replaces the PHY word while rx is held,
   // so no partial frame reaches the MAC
   always_ff @(posedge clk156 or posedge reset)
   begin
      if (reset)
      begin
         xgmii_rx       <= IDLE_WORD;
         rx_error_count <= '0;
      end
      else
      begin
         xgmii_rx <= core_reset_rx ? IDLE_WORD : xgmii_rx_phy;
         // one count per word, however many lanes are bad
         if (!core_reset_rx && word_err)
            rx_error_count <= rx_error_count + 1'b1;
      end
   end

   // MAC sees idle in the cycle after the rx core was held
   a_idle_in_reset: assert property (
      @(posedge clk156) disable iff (reset)
      core_reset_rx |=> (xgmii_rx == IDLE_WORD)
   );

endmodule

// File: logic/rx_fault_monitor.sv
// ----------------------------------------------------------------------
// receive fault monitor
// watches the rx stream for local and remote fault ordered sets,
// keeps the link fault status and counts received frames
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module rx_fault_monitor
   import xphy_pkg::*;
(
   input  logic                   clk156,
   input  logic                   reset,
   input  logic                   core_reset_rx,
   input  xgmii_word_t            xgmii_rx,
   output logic                   local_fault,
   output logic                   remote_fault,
   output logic [COUNT_WIDTH-1:0] rx_frame_count
);

   // word classification
   logic is_seq;
   logic is_local;
   logic is_remote;
   logic is_fault;
   logic is_start;

   // consecutive fault words of one type, and consecutive clean words
   logic [SET_CNT_WIDTH-1:0]   set_cnt;
   logic [SET_CNT_WIDTH-1:0]   set_cnt_nxt;
   logic [CLEAR_CNT_WIDTH-1:0] clear_cnt;
   logic [CLEAR_CNT_WIDTH-1:0] clear_cnt_nxt;
   // type of the fault run in progress, 1 for local
   logic                       run_local;

   // sequence column, fault code sits in lane 3
   assign is_seq    = xgmii_rx.ctrl[0] && (xgmii_rx.data[7:0] == XGMII_SEQUENCE);
   assign is_local  = is_seq && (xgmii_rx.data[31:24] == SEQ_LOCAL_FAULT);
   assign is_remote = is_seq && (xgmii_rx.data[31:24] == SEQ_REMOTE_FAULT);
   assign is_fault  = is_local || is_remote;
   assign is_start  = xgmii_rx.ctrl[0] && (xgmii_rx.data[7:0] == XGMII_START);

   // next run lengths, both saturate at their thresholds
   always_comb
   begin
      set_cnt_nxt   = set_cnt;
      clear_cnt_nxt = clear_cnt;
      if (is_fault)
      begin
         clear_cnt_nxt = '0;
         // other fault type restarts the run
         if ((set_cnt != '0) && (run_local == is_local))
         begin
            if (set_cnt != SET_CNT_WIDTH'(FAULT_SET_COUNT))
               set_cnt_nxt = set_cnt + 1'b1;
         end
         else
         begin
            set_cnt_nxt = SET_CNT_WIDTH'(1);
         end
      end
      else
      begin
         set_cnt_nxt = '0;
         if (clear_cnt != CLEAR_CNT_WIDTH'(FAULT_CLEAR_COUNT))
            clear_cnt_nxt = clear_cnt + 1'b1;
      end
   end

   // flags move on the same edge as the counter reaching threshold
   always_ff @(posedge clk156 or posedge reset)
   begin
      if (reset)
      begin
         set_cnt        <= '0;
         clear_cnt      <= '0;
         run_local      <= 1'b0;
         local_fault    <= 1'b0;
         remote_fault   <= 1'b0;
         rx_frame_count <= '0;
      end
      else if (!core_reset_rx)
      begin
         set_cnt   <= set_cnt_nxt;
         clear_cnt <= clear_cnt_nxt;
         if (is_fault)
            run_local <= is_local;
         // the newer fault type wins, flags stay exclusive
         if (is_fault && (set_cnt_nxt == SET_CNT_WIDTH'(FAULT_SET_COUNT)))
         begin
            local_fault  <= is_local;
            remote_fault <= is_remote;
         end
         else if (!is_fault && (clear_cnt_nxt == CLEAR_CNT_WIDTH'(FAULT_CLEAR_COUNT)))
         begin
            local_fault  <= 1'b0;
            remote_fault <= 1'b0;
         end
         // start only valid in lane 0
         if (is_start)
            rx_frame_count <= rx_frame_count + 1'b1;
      end
   end

   a_faults_exclusive: assert property (
      @(posedge clk156) disable iff (reset) !(local_fault && remote_fault)
   );

endmodule

// File: logic/tx_fault_responder.sv
// ----------------------------------------------------------------------
// transmit fault responder
// registers the MAC transmit column for the PHY and applies the
// reconciliation fault rule on top of it
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module tx_fault_responder
   import xphy_pkg::*;
(
   input  logic        clk156,
   input  logic        reset,
   input  logic        core_reset_tx,
   input  logic        local_fault,
   input  logic        remote_fault,
   input  xgmii_word_t xgmii_tx,
   output xgmii_word_t xgmii_tx_phy
);

   // word picked by the reconciliation rule
   xgmii_word_t tx_sel;

   // held core first, then local fault, then remote fault
   always_comb
   begin
      if (core_reset_tx)
      begin
         // nothing from the MAC while tx core is held
         tx_sel = IDLE_WORD;
      end
      else if (local_fault)
      begin
         // we cannot hear the far end so tell it
         tx_sel = REMOTE_FAULT_WORD;
      end
      else if (remote_fault)
      begin
         // far end cannot hear us so go quiet
         tx_sel = IDLE_WORD;
      end
      else
      begin
         tx_sel = xgmii_tx;
      end
   end

   // one cycle to the PHY and idle out of reset
   always_ff @(posedge clk156 or posedge reset)
   begin
      if (reset)
         xgmii_tx_phy <= IDLE_WORD;
      else
         xgmii_tx_phy <= tx_sel;
   end

endmodule

// File: logic/xphy_glue_top.sv
// ----------------------------------------------------------------------
// xphy glue top
// reset sequencing and the rx/tx XGMII paths between MAC and PHY core
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module xphy_glue_top
   import xphy_pkg::*;
(
   input  logic                   clk156,
   input  logic                   reset,
   input  logic                   tx_resetdone,
   input  logic                   rx_resetdone,
   input  logic                   tx_fault,
   input  logic                   signal_detect,
   // MAC transmit and PHY receive columns
   input  xgmii_word_t            xgmii_tx,
   input  xgmii_word_t            xgmii_rx_phy,
   // PHY transmit and MAC receive columns
   output xgmii_word_t            xgmii_tx_phy,
   output xgmii_word_t            xgmii_rx,
   output logic                   resetdone,
   output logic                   core_reset_tx,
   output logic                   core_reset_rx,
   output logic                   local_fault,
   output logic                   remote_fault,
   output logic [COUNT_WIDTH-1:0] rx_frame_count,
   output logic [COUNT_WIDTH-1:0] rx_error_count
);

   // core resets for both directions
   phy_reset_ctrl u_reset_ctrl (
      .clk156        (clk156),
      .reset         (reset),
      .tx_resetdone  (tx_resetdone),
      .rx_resetdone  (rx_resetdone),
      .tx_fault      (tx_fault),
      .signal_detect (signal_detect),
      .resetdone     (resetdone),
      .core_reset_tx (core_reset_tx),
      .core_reset_rx (core_reset_rx)
   );

   // PHY to MAC, registered once
   rx_input_stage u_rx_input (
      .clk156         (clk156),
      .reset          (reset),
      .core_reset_rx  (core_reset_rx),
      .xgmii_rx_phy   (xgmii_rx_phy),
      .xgmii_rx       (xgmii_rx),
      .rx_error_count (rx_error_count)
   );

   // link status from the registered rx stream
   rx_fault_monitor u_fault_mon (
      .clk156         (clk156),
      .reset          (reset),
      .core_reset_rx  (core_reset_rx),
      .xgmii_rx       (xgmii_rx),
      .local_fault    (local_fault),
      .remote_fault   (remote_fault),
      .rx_frame_count (rx_frame_count)
   );

   // MAC to PHY with fault substitution
   tx_fault_responder u_tx_resp (
      .clk156        (clk156),
      .reset         (reset),
      .core_reset_tx (core_reset_tx),
      .local_fault   (local_fault),
      .remote_fault  (remote_fault),
      .xgmii_tx      (xgmii_tx),
      .xgmii_tx_phy  (xgmii_tx_phy)
   );

endmodule

// File: dv/tb_xphy.sv
// ----------------------------------------------------------------------
// xphy glue testbench
// replays per-cycle rows from dv/xphy_input.txt into the DUT and
// compares every output against the expected columns of each row
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module tb_xphy
   import xphy_pkg::*;
();

   logic                   clk156;
   logic                   reset;
   logic                   tx_resetdone;
   logic                   rx_resetdone;
   logic                   tx_fault;
   logic                   signal_detect;
   xgmii_word_t            xgmii_tx;
   xgmii_word_t            xgmii_rx_phy;
   xgmii_word_t            xgmii_tx_phy;
   xgmii_word_t            xgmii_rx;
   logic                   resetdone;
   logic                   core_reset_tx;
   logic                   core_reset_rx;
   logic                   local_fault;
   logic                   remote_fault;
   logic [COUNT_WIDTH-1:0] rx_frame_count;
   logic [COUNT_WIDTH-1:0] rx_error_count;

   // run totals and totals of the test in progress
   int checks;
   int errors;
   int test_checks;
   int test_errors;

   xphy_glue_top DUT (.*);

   // 156.25 MHz stand-in, 40 ns period
   initial
   begin
      clk156 = 1'b0;
      forever
         #20 clk156 = ~clk156;
   end

   // word codes of the data file, {data, ctrl} with lane 0 in the low byte
   function automatic logic [71:0] word_of(input int code);
      case (code)
         1:       word_of = {64'hD5555555555555FB, 8'h01};  // start + preamble
         2:       word_of = {64'h8877665544332211, 8'h00};
         3:       word_of = {64'hA1B2FEC4D5E6F708, 8'h20};  // error in lane 5
         4:       word_of = {64'h0100009C0100009C, 8'h11};  // local fault
         5:       word_of = {64'h0200009C0200009C, 8'h11};  // remote fault
         6:       word_of = {64'h0F1E2D3C4B5A6978, 8'h00};
         7:       word_of = {64'h00000000000000FE, 8'h00};  // FE as plain data
         default: word_of = {64'h0707070707070707, 8'hFF};  // idle
      endcase
   endfunction

   function automatic string test_name(input int id);
      case (id)
         1:       test_name = "reset sequencing";
         2:       test_name = "receive path";
         3:       test_name = "error counting";
         4:       test_name = "local fault";
         5:       test_name = "remote fault";
         default: test_name = "unnamed";
      endcase
   endfunction

   task automatic check_value(input string name, input logic [71:0] act,
                              input logic [71:0] exp);
      checks++;
      test_checks++;
      assert (act === exp)
      else
      begin
         errors++;
         test_errors++;
         $display("FAIL at %0d ns %s expected %0h got %0h", $time, name, exp, act);
      end
   endtask

   task automatic report_test(input int id);
      $display("test %0d %s finished: %0d checks, %0d errors",
               id, test_name(id), test_checks, test_errors);
   endtask

   initial
   begin
      int    fd;
      int    n;
      int    wait_cycles;
      int    cur_test;
      bit    aborted;
      string line;
      // one data row: inputs, then expected outputs
      int    test_id, rpt, trd, rrd, txf, sd, tx_code, rx_code;
      int    exp_tx, exp_rx, exp_rd, exp_crt, exp_crr, exp_lf, exp_rf;
      int    exp_frames, exp_errs;

      checks        = 0;
      errors        = 0;
      aborted       = 1'b0;
      cur_test      = 0;
      // all link conditions good while the system reset is applied
      reset         = 1'b1;
      tx_resetdone  = 1'b1;
      rx_resetdone  = 1'b1;
      tx_fault      = 1'b0;
      signal_detect = 1'b1;
      xgmii_tx      = word_of(0);
      xgmii_rx_phy  = word_of(0);
      repeat (5) @(negedge clk156);
      reset = 1'b0;

      // cores come out of reset through the synchronizers
      wait_cycles = 0;
      while ((core_reset_tx || core_reset_rx) && (wait_cycles < 20))
      begin
         @(negedge clk156);
         wait_cycles++;
      end
      if (core_reset_tx || core_reset_rx)
      begin
         $display("timeout: core_reset_tx and core_reset_rx never released");
         aborted = 1'b1;
      end

      fd = $fopen("dv/xphy_input.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open dv/xphy_input.txt for reading");
         aborted = 1'b1;
      end

      while (!aborted && !$feof(fd))
      begin
         line = "";
         n    = $fgets(line, fd);
         // skip comment and blank lines
         if ((n > 0) && (line.len() > 1) && (line.getc(0) != "#"))
         begin
            n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                        test_id, rpt, trd, rrd, txf, sd, tx_code, rx_code,
                        exp_tx, exp_rx, exp_rd, exp_crt, exp_crr, exp_lf, exp_rf,
                        exp_frames, exp_errs);
            if (n != 17)
            begin
               $display("malformed row in dv/xphy_input.txt: %s", line);
               errors++;
            end
            else
            begin
               // a new test id closes the previous test
               if (test_id != cur_test)
               begin
                  if (cur_test != 0)
                     report_test(cur_test);
                  cur_test    = test_id;
                  test_checks = 0;
                  test_errors = 0;
               end
               // drive on the falling edge, hold for rpt cycles
               tx_resetdone  = trd[0];
               rx_resetdone  = rrd[0];
               tx_fault      = txf[0];
               signal_detect = sd[0];
               xgmii_tx      = word_of(tx_code);
               xgmii_rx_phy  = word_of(rx_code);
               if (rpt > 1)
                  repeat (rpt - 1) @(negedge clk156);
               // sample mid high phase of the last cycle
               @(posedge clk156);
               #10;
               check_value("xgmii_tx_phy", xgmii_tx_phy, word_of(exp_tx));
               check_value("xgmii_rx", xgmii_rx, word_of(exp_rx));
               check_value("resetdone", 72'(resetdone), 72'(exp_rd));
               check_value("core_reset_tx", 72'(core_reset_tx), 72'(exp_crt));
               check_value("core_reset_rx", 72'(core_reset_rx), 72'(exp_crr));
               check_value("local_fault", 72'(local_fault), 72'(exp_lf));
               check_value("remote_fault", 72'(remote_fault), 72'(exp_rf));
               check_value("rx_frame_count", 72'(rx_frame_count), 72'(exp_frames));
               check_value("rx_error_count", 72'(rx_error_count), 72'(exp_errs));
               @(negedge clk156);
            end
         end
      end
      if (cur_test != 0)
         report_test(cur_test);
      if (fd != 0)
         $fclose(fd);

      $display("total: %0d checks, %0d errors", checks, errors);
      if ((errors == 0) && !aborted && (checks > 0))
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

// File: dv/xphy_input.txt
# test rpt trd rrd txf sd tx rx_phy | expected: tx_phy rx resetdone crst_tx crst_rx lf rf frames errs
# word codes: 0 idle, 1 start, 2 data, 3 error lane 5, 4 local fault, 5 remote fault, 6 data, 7 FE data
1 1 1 1 0 0 2 2 2 2 1 0 0 0 0 0 0
1 1 1 1 0 0 2 2 2 2 1 1 1 0 0 0 0
1 1 1 1 0 1 2 2 0 0 1 1 1 0 0 0 0
1 1 1 1 0 1 2 2 0 0 1 0 0 0 0 0 0
1 1 1 1 1 1 2 2 2 2 1 0 0 0 0 0 0
1 1 1 1 1 1 2 2 2 2 1 1 1 0 0 0 0
1 1 1 1 0 1 2 2 0 0 1 1 1 0 0 0 0
1 1 1 1 0 1 2 2 0 0 1 0 0 0 0 0 0
1 1 1 0 0 1 2 2 2 2 0 0 0 0 0 0 0
1 1 1 1 0 1 2 2 2 2 1 0 1 0 0 0 0
1 1 1 1 0 1 2 2 2 0 1 0 0 0 0 0 0
2 1 1 1 0 1 2 1 2 1 1 0 0 0 0 0 0
2 1 1 1 0 1 2 2 2 2 1 0 0 0 0 1 0
2 2 1 1 0 1 2 2 2 2 1 0 0 0 0 1 0
2 1 1 0 0 1 2 2 2 2 0 0 0 0 0 1 0
2 1 1 0 0 1 2 2 2 2 0 0 1 0 0 1 0
2 3 1 0 0 1 2 1 2 0 0 0 1 0 0 1 0
2 2 1 1 0 1 2 2 2 0 1 0 0 0 0 1 0
2 1 1 1 0 1 2 2 2 2 1 0 0 0 0 1 0
3 1 1 1 0 1 2 3 2 3 1 0 0 0 0 1 1
3 1 1 1 0 1 2 7 2 7 1 0 0 0 0 1 1
3 3 1 1 0 1 2 3 2 3 1 0 0 0 0 1 4
3 2 1 1 0 1 2 2 2 2 1 0 0 0 0 1 4
4 3 1 1 0 1 2 4 2 4 1 0 0 0 0 1 4
4 1 1 1 0 1 2 4 2 4 1 0 0 0 0 1 4
4 1 1 1 0 1 6 2 6 2 1 0 0 1 0 1 4
4 14 1 1 0 1 6 2 5 2 1 0 0 1 0 1 4
4 1 1 1 0 1 6 2 5 2 1 0 0 1 0 1 4
4 1 1 1 0 1 6 2 5 2 1 0 0 0 0 1 4
4 1 1 1 0 1 6 2 6 2 1 0 0 0 0 1 4
5 4 1 1 0 1 6 5 6 5 1 0 0 0 0 1 4
5 1 1 1 0 1 6 4 6 4 1 0 0 0 1 1 4
5 2 1 1 0 1 6 4 0 4 1 0 0 0 1 1 4
5 1 1 1 0 1 6 4 0 4 1 0 0 0 1 1 4
5 1 1 1 0 1 6 2 0 2 1 0 0 1 0 1 4
5 1 1 1 0 1 6 2 5 2 1 0 0 1 0 1 4

// File: files.f
logic/xphy_pkg.sv
logic/phy_reset_ctrl.sv
logic/rx_input_stage.sv
logic/rx_fault_monitor.sv
logic/tx_fault_responder.sv
logic/xphy_glue_top.sv
dv/tb_xphy.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the xphy testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_xphy
sim_out=$(./obj_dir/Vtb_xphy)
echo "$sim_out"
if grep -qF '*** PASSED ***' <<< "$sim_out"
then
   exit 0
fi
exit 1
